// ==== mem_bus_settings.svh ====
`ifndef MEM_BUS_SETTINGS_SVH
`define MEM_BUS_SETTINGS_SVH

////////////////////////////////////////////////////////////
// memory bus widths
////////////////////////////////////////////////////////////

// byte address into memory
`define MB_ADDR_W 32

// one memory beat, a double word
`define MB_BEAT_W 64

// processor word, half a beat
`define MB_WORD_W 32

// memory transaction tag, zero means no tag
`define MB_TAG_W 4

`endif

// ==== bus_proto_pkg.sv ====
`include "mem_bus_settings.svh"

package bus_proto_pkg;

    ////////////////////////////////////////////////////////////
    // memory command and machine encodings
    ////////////////////////////////////////////////////////////

    // command on the memory port
    typedef enum logic [1:0] {
        cmd_none  = 2'h0,
        cmd_load  = 2'h1,
        cmd_store = 2'h2
    } bus_cmd_t;

    // bus transaction machine states
    typedef enum logic [2:0] {
        st_idle       = 3'h0,
        st_imem_load  = 3'h1,
        st_dmem_load  = 3'h2,
        st_dmem_store = 3'h3,
        st_settle     = 3'h4
    } bus_state_t;

    // who owns the current transaction
    typedef enum logic [1:0] {
        kind_none  = 2'h0,
        kind_fetch = 2'h1,
        kind_load  = 2'h2,
        kind_store = 2'h3
    } req_kind_t;

    // granted request, as offered to the bus
    typedef struct packed {
        req_kind_t              kind;
        logic [`MB_ADDR_W-1:0]  addr;
        // store payload, ignored for loads and fetches
        logic [`MB_WORD_W-1:0]  wdata;
    } bus_req_t;

endpackage

// ==== mem_word_pkg.sv ====
`include "mem_bus_settings.svh"

package mem_word_pkg;

    ////////////////////////////////////////////////////////////
    // memory beat views
    ////////////////////////////////////////////////////////////

    // one beat seen as a double word or as two words
    // words[0] sits in the low half
    typedef union packed {
        logic [`MB_BEAT_W-1:0]                               dword;
        logic [`MB_BEAT_W/`MB_WORD_W-1:0][`MB_WORD_W-1:0]    words;
    } mem_beat_u;

    // completion handed from the FSM to the router
    // word select comes from the held request, not from here
    typedef struct packed {
        bus_proto_pkg::req_kind_t kind;
        // high for the single completing cycle
        logic                     strobe;
    } bus_done_t;

endpackage

// ==== bus_request_select.sv ====
`timescale 1ns/100ps

`include "mem_bus_settings.svh"

module bus_request_select (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      fetch_req,
    input  logic [`MB_ADDR_W-1:0]     fetch_addr,
    input  bus_proto_pkg::bus_cmd_t   data_cmd,
    input  logic [`MB_ADDR_W-1:0]     data_addr,
    input  logic [`MB_WORD_W-1:0]     data_wdata,
    input  logic                      bus_idle,
    output bus_proto_pkg::bus_req_t   grant,
    output bus_proto_pkg::bus_req_t   held_req
);

    // request accepted at this edge
    logic issue;

    ////////////////////////////////////////////////////////////
    // arbitration, data side wins
    ////////////////////////////////////////////////////////////

    always_comb begin
        grant.kind  = bus_proto_pkg::kind_none;
        grant.addr  = '0;
        grant.wdata = '0;
        // nothing granted while a transaction is in flight
        if (bus_idle) begin
            if (data_cmd == bus_proto_pkg::cmd_store) begin
                grant.kind  = bus_proto_pkg::kind_store;
                grant.addr  = data_addr;
                grant.wdata = data_wdata;
            end else if (data_cmd == bus_proto_pkg::cmd_load) begin
                grant.kind = bus_proto_pkg::kind_load;
                grant.addr = data_addr;
            end else if (fetch_req) begin
                // fetch only when data side is quiet
                grant.kind = bus_proto_pkg::kind_fetch;
                grant.addr = fetch_addr;
            end
        end
    end

    assign issue = bus_idle && (grant.kind != bus_proto_pkg::kind_none);

    ////////////////////////////////////////////////////////////
    // held copy for the router
    ////////////////////////////////////////////////////////////

    // owner of the transaction
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            held_req.kind <= bus_proto_pkg::kind_none;
        end else if (issue) begin
            held_req.kind <= grant.kind;
        end
    end

    // address bit 2 later picks the word half
    always_ff @(posedge clock) begin
        if (issue) begin
            held_req.addr  <= grant.addr;
            held_req.wdata <= grant.wdata;
        end
    end

endmodule

// ==== bus_transaction_fsm.sv ====
`timescale 1ns/100ps

`include "mem_bus_settings.svh"

module bus_transaction_fsm (
    input  logic                      clock,
    input  logic                      rst_n,
    input  bus_proto_pkg::bus_req_t   grant,
    input  logic [`MB_TAG_W-1:0]      mem_response,
    input  logic [`MB_TAG_W-1:0]      mem_tag,
    output logic                      bus_idle,
    output bus_proto_pkg::bus_cmd_t   mem_cmd,
    output logic [`MB_ADDR_W-1:0]     mem_addr,
    output logic [`MB_BEAT_W-1:0]     mem_wdata,
    output mem_word_pkg::bus_done_t   done
);

    bus_proto_pkg::bus_state_t state;
    bus_proto_pkg::bus_state_t state_next;
    bus_proto_pkg::bus_cmd_t   issue_cmd;
    // sticky copy of the last accepted tag
    logic [`MB_TAG_W-1:0]      resp_tag;
    logic                      resp_seen;
    logic                      resp_valid;
    logic                      issue;
    logic                      tag_hit;
    logic                      complete;

    assign bus_idle   = (state == bus_proto_pkg::st_idle);
    assign issue      = bus_idle && (grant.kind != bus_proto_pkg::kind_none);
    assign resp_valid = (mem_response != '0);
    assign issue_cmd  = (grant.kind == bus_proto_pkg::kind_store) ?
                        bus_proto_pkg::cmd_store : bus_proto_pkg::cmd_load;

    // beat tag against a response arriving now or the latched one
    always_comb begin
        if (mem_tag == '0) begin
            tag_hit = 1'b0;
        end else if (resp_valid) begin
            tag_hit = (mem_tag == mem_response);
        end else begin
            tag_hit = resp_seen && (mem_tag == resp_tag);
        end
    end

    ////////////////////////////////////////////////////////////
    // next state and completion
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        complete   = 1'b0;
        done.kind  = bus_proto_pkg::kind_none;
        case (state)
            bus_proto_pkg::st_idle: begin
                if (issue) begin
                    case (grant.kind)
                        bus_proto_pkg::kind_fetch: state_next = bus_proto_pkg::st_imem_load;
                        bus_proto_pkg::kind_load:  state_next = bus_proto_pkg::st_dmem_load;
                        default:                   state_next = bus_proto_pkg::st_dmem_store;
                    endcase
                end
            end
            bus_proto_pkg::st_imem_load: begin
                done.kind = bus_proto_pkg::kind_fetch;
                complete  = tag_hit;
            end
            bus_proto_pkg::st_dmem_load: begin
                done.kind = bus_proto_pkg::kind_load;
                complete  = tag_hit;
            end
            bus_proto_pkg::st_dmem_store: begin
                // store is over once memory accepts it
                done.kind = bus_proto_pkg::kind_store;
                complete  = resp_valid;
            end
            bus_proto_pkg::st_settle: begin
                // one quiet cycle so the requester can drop its level
                state_next = bus_proto_pkg::st_idle;
            end
            default: begin
                state_next = bus_proto_pkg::st_idle;
            end
        endcase
        if (complete) begin
            state_next = bus_proto_pkg::st_settle;
        end
        done.strobe = complete;
    end

    ////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state     <= bus_proto_pkg::st_idle;
            mem_cmd   <= bus_proto_pkg::cmd_none;
            resp_tag  <= '0;
            resp_seen <= 1'b0;
        end else begin
            state <= state_next;
            // command strobe lasts exactly one cycle
            mem_cmd <= issue ? issue_cmd : bus_proto_pkg::cmd_none;
            if (resp_valid) begin
                resp_tag <= mem_response;
            end
            // forget the old tag at each new issue
            if (issue) begin
                resp_seen <= 1'b0;
            end else if (resp_valid) begin
                resp_seen <= 1'b1;
            end
        end
    end

    // address and store beat, valid with the command
    always_ff @(posedge clock) begin
        if (issue) begin
            mem_addr <= grant.addr;
            if (grant.kind == bus_proto_pkg::kind_store) begin
                mem_wdata <= {{(`MB_BEAT_W-`MB_WORD_W){1'b0}}, grant.wdata};
            end else begin
                mem_wdata <= '0;
            end
        end
    end

endmodule

// ==== response_router.sv ====
`timescale 1ns/100ps

`include "mem_bus_settings.svh"

module response_router (
    input  logic                      clock,
    input  logic                      rst_n,
    input  mem_word_pkg::bus_done_t   done,
    input  bus_proto_pkg::bus_req_t   held_req,
    input  mem_word_pkg::mem_beat_u   mem_data,
    output logic                      fetch_done,
    output logic [`MB_WORD_W-1:0]     fetch_inst,
    output logic                      load_done,
    output logic [`MB_WORD_W-1:0]     load_data,
    output logic                      store_done
);

    // word half picked from the beat
    logic [`MB_WORD_W-1:0] sel_word;
    logic                  hit_fetch;
    logic                  hit_load;
    logic                  hit_store;

    // address bit 2 chooses high or low word
    assign sel_word = mem_data.words[held_req.addr[2]];

    // decode the completion by owner
    assign hit_fetch = done.strobe && (done.kind == bus_proto_pkg::kind_fetch);
    assign hit_load  = done.strobe && (done.kind == bus_proto_pkg::kind_load);
    assign hit_store = done.strobe && (done.kind == bus_proto_pkg::kind_store);

    ////////////////////////////////////////////////////////////
    // completion pulses
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            fetch_done <= 1'b0;
            load_done  <= 1'b0;
            store_done <= 1'b0;
        end else begin
            // done strobe is one cycle, so are these
            fetch_done <= hit_fetch;
            load_done  <= hit_load;
            store_done <= hit_store;
        end
    end

    // word capture, held until the next completion of that kind
    always_ff @(posedge clock) begin
        if (hit_fetch) begin
            fetch_inst <= sel_word;
        end
        if (hit_load) begin
            load_data <= sel_word;
        end
    end

endmodule

// ==== mem_bus_top.sv ====
`timescale 1ns/100ps

`include "mem_bus_settings.svh"

module mem_bus_top (
    input  logic                      clock,
    input  logic                      rst_n,
    // fetch side
    input  logic                      fetch_req,
    input  logic [`MB_ADDR_W-1:0]     fetch_addr,
    output logic                      fetch_done,
    output logic [`MB_WORD_W-1:0]     fetch_inst,
    // data side
    input  bus_proto_pkg::bus_cmd_t   data_cmd,
    input  logic [`MB_ADDR_W-1:0]     data_addr,
    input  logic [`MB_WORD_W-1:0]     data_wdata,
    output logic                      load_done,
    output logic [`MB_WORD_W-1:0]     load_data,
    output logic                      store_done,
    // memory port
    input  logic [`MB_TAG_W-1:0]      mem_response,
    input  logic [`MB_TAG_W-1:0]      mem_tag,
    input  mem_word_pkg::mem_beat_u   mem_data,
    output bus_proto_pkg::bus_cmd_t   mem_cmd,
    output logic [`MB_ADDR_W-1:0]     mem_addr,
    output logic [`MB_BEAT_W-1:0]     mem_wdata
);

    bus_proto_pkg::bus_req_t grant;
    bus_proto_pkg::bus_req_t held_req;
    mem_word_pkg::bus_done_t done;
    logic                    bus_idle;

    // request selection
    bus_request_select u_select (
        .clock      (clock),
        .rst_n      (rst_n),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .data_cmd   (data_cmd),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .bus_idle   (bus_idle),
        .grant      (grant),
        .held_req   (held_req)
    );

    // bus transaction machine
    bus_transaction_fsm u_fsm (
        .clock        (clock),
        .rst_n        (rst_n),
        .grant        (grant),
        .mem_response (mem_response),
        .mem_tag      (mem_tag),
        .bus_idle     (bus_idle),
        .mem_cmd      (mem_cmd),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .done         (done)
    );

    // response routing
    response_router u_router (
        .clock      (clock),
        .rst_n      (rst_n),
        .done       (done),
        .held_req   (held_req),
        .mem_data   (mem_data),
        .fetch_done (fetch_done),
        .fetch_inst (fetch_inst),
        .load_done  (load_done),
        .load_data  (load_data),
        .store_done (store_done)
    );

endmodule

// ==== mem_bus_asserts.sv ====
`timescale 1ns/100ps

module mem_bus_asserts (
    input logic                    clock,
    input logic                    rst_n,
    input bus_proto_pkg::bus_cmd_t mem_cmd,
    input logic                    fetch_done,
    input logic                    load_done,
    input logic                    store_done
);

    // count of failed assertions
    int fail_count = 0;

    ////////////////////////////////////////////////////////////
    // memory port and completion rules
    ////////////////////////////////////////////////////////////

    // command is a single-cycle strobe
    cmd_strobe: assert property (@(posedge clock) disable iff (!rst_n)
        (mem_cmd != bus_proto_pkg::cmd_none) |=> (mem_cmd == bus_proto_pkg::cmd_none))
        else begin
            fail_count = fail_count + 1;
            $error("mem_cmd active in two consecutive cycles");
        end

    // one owner per completion
    done_onehot: assert property (@(posedge clock) disable iff (!rst_n)
        $onehot0({fetch_done, load_done, store_done}))
        else begin
            fail_count = fail_count + 1;
            $error("more than one done pulse in a cycle");
        end

    fetch_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        fetch_done |=> !fetch_done)
        else begin
            fail_count = fail_count + 1;
            $error("fetch_done longer than one cycle");
        end

    load_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        load_done |=> !load_done)
        else begin
            fail_count = fail_count + 1;
            $error("load_done longer than one cycle");
        end

    store_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        store_done |=> !store_done)
        else begin
            fail_count = fail_count + 1;
            $error("store_done longer than one cycle");
        end

    // outputs quiet right after reset
    reset_quiet: assert property (@(posedge clock)
        $rose(rst_n) |-> (mem_cmd == bus_proto_pkg::cmd_none &&
                          !fetch_done && !load_done && !store_done))
        else begin
            fail_count = fail_count + 1;
            $error("outputs active in the cycle after reset");
        end

endmodule

// ==== tb_mem_bus.sv ====
`timescale 1ns/100ps

`include "mem_bus_settings.svh"

module tb_mem_bus;

    localparam int num_trans      = 13;
    localparam int timeout_cycles = 40 * num_trans;
    // distinct masks for the two halves of a reference beat
    localparam logic [`MB_WORD_W-1:0] low_key  = 32'h5a3c96e1;
    localparam logic [`MB_WORD_W-1:0] high_key = 32'hc3a50f78;

    // DUT inputs
    logic                       clock        = 1'b0;
    logic                       rst_n        = 1'b0;
    logic                       fetch_req    = 1'b0;
    logic [`MB_ADDR_W-1:0]      fetch_addr   = '0;
    bus_proto_pkg::bus_cmd_t    data_cmd     = bus_proto_pkg::cmd_none;
    logic [`MB_ADDR_W-1:0]      data_addr    = '0;
    logic [`MB_WORD_W-1:0]      data_wdata   = '0;
    logic [`MB_TAG_W-1:0]       mem_response = '0;
    logic [`MB_TAG_W-1:0]       mem_tag      = '0;
    mem_word_pkg::mem_beat_u    mem_data     = '0;
    // DUT outputs
    logic                       fetch_done;
    logic [`MB_WORD_W-1:0]      fetch_inst;
    logic                       load_done;
    logic [`MB_WORD_W-1:0]      load_data;
    logic                       store_done;
    bus_proto_pkg::bus_cmd_t    mem_cmd;
    logic [`MB_ADDR_W-1:0]      mem_addr;
    logic [`MB_BEAT_W-1:0]      mem_wdata;

    // expected values from the stimulus
    bus_proto_pkg::bus_cmd_t    exp_cmd   = bus_proto_pkg::cmd_none;
    logic [`MB_ADDR_W-1:0]      exp_addr  = '0;
    logic [`MB_BEAT_W-1:0]      exp_wdata = '0;
    logic [`MB_WORD_W-1:0]      exp_fetch = '0;
    logic [`MB_WORD_W-1:0]      exp_load  = '0;
    logic                       fetch_pend = 1'b0;
    logic                       load_pend  = 1'b0;
    logic                       store_pend = 1'b0;
    // memory model controls and state
    logic [2:0]                 beat_delay = 3'd1;
    logic                       decoy_on   = 1'b0;
    logic [`MB_TAG_W-1:0]       tag_ctr    = 4'h1;
    logic [`MB_TAG_W-1:0]       pend_tag   = '0;
    logic [`MB_ADDR_W-1:0]      pend_addr  = '0;
    logic                       beat_busy  = 1'b0;
    logic [2:0]                 beat_cnt   = '0;
    logic                       decoy_left = 1'b0;
    // checker and run control
    logic                       beat_seen  = 1'b0;
    logic [31:0]                lfsr_state = 32'h60cf1791;
    int                         cycles     = 0;

    mem_bus_top UUT (.*);

    bind mem_bus_top mem_bus_asserts u_asserts (
        .clock      (clock),
        .rst_n      (rst_n),
        .mem_cmd    (mem_cmd),
        .fetch_done (fetch_done),
        .load_done  (load_done),
        .store_done (store_done)
    );

    always #20 clock = ~clock;

    ////////////////////////////////////////////////////////////
    // random source and reference model
    ////////////////////////////////////////////////////////////

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] step_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = step_lfsr(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // double word index with each half masked
    function automatic logic [`MB_BEAT_W-1:0] beat_for_addr(input logic [`MB_ADDR_W-1:0] addr);
        logic [`MB_WORD_W-1:0] idx;
        idx = addr >> 3;
        return {idx ^ high_key, idx ^ low_key};
    endfunction

    // word the requester should receive
    function automatic logic [`MB_WORD_W-1:0] expected_word(input logic [`MB_ADDR_W-1:0] addr);
        logic [`MB_BEAT_W-1:0] beat;
        beat = beat_for_addr(addr);
        return addr[2] ? beat[63:32] : beat[31:0];
    endfunction

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    task automatic check_cmd(input string name, input bus_proto_pkg::bus_cmd_t got,
                             input bus_proto_pkg::bus_cmd_t exp);
        if (got !== exp)
            abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input logic [`MB_ADDR_W-1:0] got,
                              input logic [`MB_ADDR_W-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_word(input string name, input logic [`MB_WORD_W-1:0] got,
                              input logic [`MB_WORD_W-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_beat(input string name, input logic [`MB_BEAT_W-1:0] got,
                              input logic [`MB_BEAT_W-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    ////////////////////////////////////////////////////////////
    // memory model
    ////////////////////////////////////////////////////////////

    // response one cycle after each command
    // load beats follow after beat_delay cycles
    always @(posedge clock) begin
        mem_response <= '0;
        mem_tag      <= '0;
        mem_data     <= '0;
        if (!rst_n) begin
            tag_ctr   <= 4'h1;
            pend_tag  <= '0;
            beat_busy <= 1'b0;
        end else if (mem_cmd != bus_proto_pkg::cmd_none) begin
            mem_response <= tag_ctr;
            pend_tag     <= tag_ctr;
            pend_addr    <= mem_addr;
            // tags count 1..15 and skip zero
            tag_ctr    <= (tag_ctr == 4'hf) ? 4'h1 : tag_ctr + 4'h1;
            beat_busy  <= (mem_cmd == bus_proto_pkg::cmd_load);
            beat_cnt   <= beat_delay;
            decoy_left <= decoy_on;
        end else if (beat_busy) begin
            // stray beat under the next tag and never the pending one
            if (decoy_left) begin
                mem_tag        <= tag_ctr;
                mem_data.dword <= ~beat_for_addr(pend_addr);
                decoy_left     <= 1'b0;
            end
            if (beat_cnt == 3'd1) begin
                mem_tag        <= pend_tag;
                mem_data.dword <= beat_for_addr(pend_addr);
                beat_busy      <= 1'b0;
            end
            beat_cnt <= beat_cnt - 3'd1;
        end
    end

    ////////////////////////////////////////////////////////////
    // response checker and timeout
    ////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        if (rst_n) begin
            // completion only after the matching beat was on the bus
            if ((fetch_done || load_done) && !beat_seen)
                abort_run("load completed before the beat with the matching tag arrived");
            if (fetch_done) begin
                if (!fetch_pend)
                    abort_run("fetch_done pulsed with no fetch pending");
                check_word("fetch_inst", fetch_inst, exp_fetch);
            end
            if (load_done) begin
                if (!load_pend)
                    abort_run("load_done pulsed with no load pending");
                check_word("load_data", load_data, exp_load);
            end
            if (store_done && !store_pend)
                abort_run("store_done pulsed with no store pending");
            if (mem_cmd != bus_proto_pkg::cmd_none) begin
                check_cmd("mem_cmd", mem_cmd, exp_cmd);
                check_addr("mem_addr", mem_addr, exp_addr);
                if (exp_cmd == bus_proto_pkg::cmd_store)
                    check_beat("mem_wdata", mem_wdata, exp_wdata);
                beat_seen = 1'b0;
            end
            if (mem_tag != '0 && mem_tag == pend_tag)
                beat_seen = 1'b1;
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles)
            abort_run($sformatf("timeout, bus still busy after %0d cycles", cycles));
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    // beat latency 1..4
    // at least 2 when a stray beat goes first
    task automatic schedule_beat(input logic decoy);
        logic [31:0] r;
        take_bits(2, r);
        beat_delay <= (decoy && r[1:0] == 2'd0) ? 3'd2 : {1'b0, r[1:0]} + 3'd1;
        decoy_on   <= decoy;
    endtask

    task automatic expect_cmd(input bus_proto_pkg::req_kind_t kind,
                              input logic [`MB_ADDR_W-1:0] addr,
                              input logic [`MB_WORD_W-1:0] wdata);
        exp_cmd   <= (kind == bus_proto_pkg::kind_store) ?
                     bus_proto_pkg::cmd_store : bus_proto_pkg::cmd_load;
        exp_addr  <= addr;
        exp_wdata <= {32'h0, wdata};
    endtask

    task automatic raise_req(input bus_proto_pkg::req_kind_t kind,
                             input logic [`MB_ADDR_W-1:0] addr,
                             input logic [`MB_WORD_W-1:0] wdata);
        case (kind)
            bus_proto_pkg::kind_fetch: begin
                fetch_req  <= 1'b1;
                fetch_addr <= addr;
                exp_fetch  <= expected_word(addr);
                fetch_pend <= 1'b1;
            end
            bus_proto_pkg::kind_load: begin
                data_cmd  <= bus_proto_pkg::cmd_load;
                data_addr <= addr;
                exp_load  <= expected_word(addr);
                load_pend <= 1'b1;
            end
            default: begin
                data_cmd   <= bus_proto_pkg::cmd_store;
                data_addr  <= addr;
                data_wdata <= wdata;
                store_pend <= 1'b1;
            end
        endcase
    endtask

    // hold the level until the done pulse and drop it on that edge
    task automatic await_done(input bus_proto_pkg::req_kind_t kind);
        logic hit;
        hit = 1'b0;
        while (!hit) begin
            @(posedge clock);
            case (kind)
                bus_proto_pkg::kind_fetch: hit = fetch_done;
                bus_proto_pkg::kind_load:  hit = load_done;
                default:                   hit = store_done;
            endcase
        end
        if (kind == bus_proto_pkg::kind_fetch) begin
            fetch_req  <= 1'b0;
            fetch_pend <= 1'b0;
        end else begin
            data_cmd   <= bus_proto_pkg::cmd_none;
            load_pend  <= 1'b0;
            store_pend <= 1'b0;
        end
    endtask

    task automatic run_one(input bus_proto_pkg::req_kind_t kind,
                           input logic [`MB_ADDR_W-1:0] addr,
                           input logic [`MB_WORD_W-1:0] wdata, input logic decoy);
        @(posedge clock);
        schedule_beat(decoy);
        expect_cmd(kind, addr, wdata);
        raise_req(kind, addr, wdata);
        await_done(kind);
    endtask

    initial begin
        logic [31:0] addr_a;
        logic [31:0] addr_b;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
        // bus quiet in the first cycle out of reset
        @(posedge clock);
        check_cmd("mem_cmd", mem_cmd, bus_proto_pkg::cmd_none);
        check_bit("fetch_done", fetch_done, 1'b0);
        check_bit("load_done", load_done, 1'b0);
        check_bit("store_done", store_done, 1'b0);
        for (int i = 0; i < 3; i++) begin
            take_bits(32, addr_a);
            run_one(bus_proto_pkg::kind_fetch, addr_a, '0, 1'b0);
        end
        // loads alternate between low and high word
        for (int i = 0; i < 4; i++) begin
            take_bits(32, addr_a);
            addr_a[2] = i[0];
            run_one(bus_proto_pkg::kind_load, addr_a, '0, 1'b0);
        end
        // data and fetch pending together so data goes first
        take_bits(32, addr_b);
        addr_a = ~addr_b;
        @(posedge clock);
        schedule_beat(1'b0);
        expect_cmd(bus_proto_pkg::kind_load, addr_b, '0);
        raise_req(bus_proto_pkg::kind_load, addr_b, '0);
        raise_req(bus_proto_pkg::kind_fetch, addr_a, '0);
        await_done(bus_proto_pkg::kind_load);
        expect_cmd(bus_proto_pkg::kind_fetch, addr_a, '0);
        await_done(bus_proto_pkg::kind_fetch);
        for (int i = 0; i < 2; i++) begin
            take_bits(32, addr_a);
            take_bits(32, addr_b);
            run_one(bus_proto_pkg::kind_store, addr_a, addr_b, 1'b0);
        end
        // stray beat ahead of the real one
        take_bits(32, addr_a);
        run_one(bus_proto_pkg::kind_fetch, addr_a, '0, 1'b1);
        take_bits(32, addr_a);
        run_one(bus_proto_pkg::kind_load, addr_a, '0, 1'b1);
        @(posedge clock);
        if (UUT.u_asserts.fail_count != 0) begin
            abort_run("a bound assertion failed during the run");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
+incdir+.
bus_proto_pkg.sv
mem_word_pkg.sv
bus_request_select.sv
bus_transaction_fsm.sv
response_router.sv
mem_bus_top.sv
mem_bus_asserts.sv
tb_mem_bus.sv

// ==== Makefile ====
# Verilator build and run of the memory bus controller testbench

TOP := tb_mem_bus

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove obj_dir"

test:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
